// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := pc_fir_regs_tb
FILELIST  := pc_fir.f
OBJ_DIR   := obj_dir
PASS_MSG  := No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/fir_cases.txt ====
# One operation per line, arguments in hex. W unit ofs data, R unit ofs expected,
# E unit bit, N cycles, M ram ovride ext, O ck lck recov trace txs any ramx, G cycles pulses
R 0 6 0FFFFFFF
R 0 8 0FFFFFFF
R 0 3 00000390
R 0 4 0FFFFFFE
R 0 0 0
R 1 6 00007FFF
R 1 3 00002AB3
R 2 4 00007FFF
R 1 0 0
R 2 0 0
R 0 5 0
R 3 6 0
O 0 0 0 0 0 0 0
W 1 0 1234
W 1 1 0FF0
W 1 2 4001
R 1 2 00004231
W 1 0 0
W 2 6 1234
W 2 7 0FF0
W 2 8 4001
R 2 6 00004231
W 2 6 7FFF
W 0 7 0FFFFFFE
E 0 0
N 3
R 0 0 00000001
O 0 0 0 1 0 0 0
W 0 1 0
W 0 8 1
E 1 0
N 3
R 1 0 00000001
O 0 0 0 0 0 0 0
W 1 0 0
W 0 4 0FFFFFEE
W 0 7 0FFFFFEF
E 0 4
N 3
O 1 0 0 0 3 1 0
E 1 5
E 2 5
N 3
R 1 0 0
R 2 0 0
W 0 1 0
W 0 8 10
W 0 4 0FFFFFFE
N 3
O 0 0 0 0 0 0 0
W 2 7 00007FFB
E 2 2
G 6 1
O 0 0 4 0 0 0 0
R 2 0 00000004
W 2 0 0
W 2 8 00000004
M 1 1 0
W 0 4 0FFFFFEE
W 0 7 0FFFFFEF
E 0 4
N 3
O 0 0 0 0 3 1 1
W 0 1 0
W 0 8 10
W 0 4 0FFFFFFE
M 0 0 0
N 2
O 0 0 0 0 0 0 0
M 0 0 1
E 0 5
N 3
R 0 0 0
M 0 0 0

// ==== bench/pc_fir_regs_tb.sv ====
//****************************
// Testbench for the FIR block top. Runs the operations listed in
// bench/fir_cases.txt and checks reads and outputs against them.
//****************************

`timescale 1ns/1ps

module pc_fir_regs_tb
   import fir_pkg::*;
();

   localparam string CASE_FILE       = "bench/fir_cases.txt";
   localparam int    CYCLES_PER_CASE = 20;
   localparam int    RESET_CYCLES    = 8;

   logic                                         nclk;
   logic                                         rst;
   reg_req_t                                     reg_req;
   logic [CORE_FIR_WIDTH-1:1]                    core_err;
   logic [NUM_THREADS-1:0][THREAD_FIR_WIDTH-1:0] thread_err;
   logic                                         ext_checkstop;
   logic                                         ram_mode;
   logic                                         xstop_report_ovride;
   logic                                         max_rec_err_cntr;
   logic [REG_WORD-1:0]                          rdata;
   logic [NUM_FIRS-1:0]                          checkstop;
   logic [NUM_FIRS-1:0]                          local_checkstop;
   logic [NUM_FIRS-1:0]                          recov_err;
   logic                                         trace_error;
   logic [NUM_THREADS-1:0]                       thread_xstop;
   logic                                         any_fir_xstop;
   logic                                         ram_mode_xstop;
   logic                                         gate_rec_err_cntr;

   int    error_count;
   int    check_count;
   logic  cases_loaded;
   string case_lines[$];

   pc_fir_regs i_dut (
      .nclk                (nclk),
      .rst                 (rst),
      .reg_req             (reg_req),
      .core_err            (core_err),
      .thread_err          (thread_err),
      .ext_checkstop       (ext_checkstop),
      .ram_mode            (ram_mode),
      .xstop_report_ovride (xstop_report_ovride),
      .max_rec_err_cntr    (max_rec_err_cntr),
      .rdata               (rdata),
      .checkstop           (checkstop),
      .local_checkstop     (local_checkstop),
      .recov_err           (recov_err),
      .trace_error         (trace_error),
      .thread_xstop        (thread_xstop),
      .any_fir_xstop       (any_fir_xstop),
      .ram_mode_xstop      (ram_mode_xstop),
      .gate_rec_err_cntr   (gate_rec_err_cntr)
   );

   always #2 nclk = ~nclk;

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      check_count++;
      if (actual !== expected)
      begin
         error_count++;
         $display("FAIL time %0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
      end
   endtask

   task automatic write_reg(input logic [31:0] unit, input logic [31:0] ofs,
                            input logic [31:0] data);
      @(posedge nclk);
      reg_req <= {1'b1, unit[UNIT_SEL_WIDTH-1:0], ofs[OFFSET_WIDTH-1:0], data};
      @(posedge nclk);
      reg_req.wr <= 1'b0;
   endtask

   // Read data is combinational, so it is sampled half a cycle after the address
   task automatic read_reg(input logic [31:0] unit, input logic [31:0] ofs,
                           input logic [31:0] expected);
      @(posedge nclk);
      reg_req <= {1'b0, unit[UNIT_SEL_WIDTH-1:0], ofs[OFFSET_WIDTH-1:0], 32'h0};
      @(negedge nclk);
      check_value($sformatf("rdata unit %0d offset %0d", unit, ofs), rdata, expected);
   endtask

   // Unit 0 is the core FIR, where bit 0 is the counter limit input
   task automatic pulse_error(input logic [31:0] unit, input logic [31:0] bit_idx);
      logic [CORE_FIR_WIDTH-1:0]   core_vec;
      logic [THREAD_FIR_WIDTH-1:0] thread_vec;
      core_vec   = '0;
      thread_vec = '0;
      @(posedge nclk);
      if (unit == 0)
      begin
         core_vec[bit_idx] = 1'b1;
         max_rec_err_cntr <= core_vec[0];
         core_err         <= core_vec[CORE_FIR_WIDTH-1:1];
      end
      else
      begin
         thread_vec[bit_idx] = 1'b1;
         thread_err[unit-1] <= thread_vec;
      end
      @(posedge nclk);
      max_rec_err_cntr <= 1'b0;
      core_err         <= '0;
      thread_err       <= '0;
   endtask

   task automatic set_mode(input logic ram, input logic ovride, input logic ext);
      @(posedge nclk);
      ram_mode            <= ram;
      xstop_report_ovride <= ovride;
      ext_checkstop       <= ext;
   endtask

   task automatic check_outputs(input logic [31:0] exp[0:6]);
      @(negedge nclk);
      check_value("checkstop", checkstop, exp[0]);
      check_value("local_checkstop", local_checkstop, exp[1]);
      check_value("recov_err", recov_err, exp[2]);
      check_value("trace_error", trace_error, exp[3]);
      check_value("thread_xstop", thread_xstop, exp[4]);
      check_value("any_fir_xstop", any_fir_xstop, exp[5]);
      check_value("ram_mode_xstop", ram_mode_xstop, exp[6]);
   endtask

   task automatic count_pulses(input int cycles, input logic [31:0] expected);
      int pulses;
      pulses = 0;
      repeat (cycles)
      begin
         @(negedge nclk);
         if (gate_rec_err_cntr)
            pulses++;
      end
      check_value("gate_rec_err_cntr pulses", pulses, expected);
   endtask

   initial
   begin : main
      int          fd;
      int          status;
      string       line;
      string       op;
      logic [31:0] args[0:6];

      nclk                = 1'b0;
      rst                 = 1'b1;
      reg_req             = '0;
      core_err            = '0;
      thread_err          = '0;
      ext_checkstop       = 1'b0;
      ram_mode            = 1'b0;
      xstop_report_ovride = 1'b0;
      max_rec_err_cntr    = 1'b0;
      error_count         = 0;
      check_count         = 0;
      cases_loaded        = 1'b0;

      fd = $fopen(CASE_FILE, "r");
      if (fd == 0)
      begin
         error_count++;
         $display("Could not open the case file %s", CASE_FILE);
      end
      else
      begin
         while (!$feof(fd))
         begin
            line = "";
            status = $fgets(line, fd);
            if (line.len() > 0 && line[0] != "#" && $sscanf(line, "%s", op) == 1)
               case_lines.push_back(line);
         end
         $fclose(fd);
      end
      cases_loaded = 1'b1;

      repeat (RESET_CYCLES) @(posedge nclk);
      rst <= 1'b0;

      foreach (case_lines[i])
      begin
         args   = '{default: '0};
         status = $sscanf(case_lines[i], "%s %h %h %h %h %h %h %h", op,
                          args[0], args[1], args[2], args[3], args[4], args[5], args[6]);
         case (op)
            "W": write_reg(args[0], args[1], args[2]);
            "R": read_reg(args[0], args[1], args[2]);
            "E": pulse_error(args[0], args[1]);
            "N": repeat (args[0]) @(posedge nclk);
            "M": set_mode(args[0][0], args[1][0], args[2][0]);
            "O": check_outputs(args);
            "G": count_pulses(args[0], args[1]);
            default:
            begin
               error_count++;
               $display("Unknown operation '%s' on case line %0d", op, i + 1);
            end
         endcase
      end

      $display("Checks: %0d  Errors: %0d", check_count, error_count);
      if (error_count == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

   // Budget of a fixed number of cycles per case line, plus reset
   initial
   begin : watchdog
      wait (cases_loaded);
      repeat (RESET_CYCLES + CYCLES_PER_CASE * (case_lines.size() + 1)) @(posedge nclk);
      $display("Timeout: the case list did not finish in the expected number of cycles");
      $display("Errors found");
      $finish;
   end

endmodule

// ==== design/fir_checkstop_ctrl.sv ====
//****************************
// Merges FIR status into capture blocking, registered checkstop
// outputs, recoverable and trace reporting and thread summaries.
//****************************

`timescale 1ns/1ps

module fir_checkstop_ctrl
   import fir_pkg::*;
(
   input  logic                         nclk,
   input  logic                         rst,
   input  fir_status_t [NUM_FIRS-1:0]   status,
   input  logic                         ext_checkstop,
   input  logic                         ram_mode,
   input  logic                         xstop_report_ovride,
   output logic        [NUM_FIRS-1:0]   block,
   output logic        [NUM_FIRS-1:0]   checkstop,
   output logic        [NUM_FIRS-1:0]   local_checkstop,
   output logic        [NUM_FIRS-1:0]   recov_err,
   output logic                         trace_error,
   output logic        [NUM_THREADS-1:0] thread_xstop,
   output logic                         any_fir_xstop,
   output logic                         ram_mode_xstop,
   output logic                         gate_rec_err_cntr
);

   logic [NUM_FIRS-1:0] xstop_int;
   logic [NUM_FIRS-1:0] lxstop_int;
   logic [NUM_FIRS-1:0] trace_int;
   logic [NUM_FIRS-1:0] recov_pulse;
   logic [NUM_FIRS-1:0] xstop_q;
   logic [NUM_FIRS-1:0] xstop_out_q;
   logic [NUM_FIRS-1:0] lxstop_out_q;
   logic                ext_xstop_q;
   logic                block_in_ram;

   always_comb
   begin
      for (int i = 0; i < NUM_FIRS; i++)
      begin
         xstop_int[i]   = status[i].xstop;
         lxstop_int[i]  = status[i].lxstop;
         recov_err[i]   = status[i].recov;
         trace_int[i]   = status[i].trace;
         recov_pulse[i] = status[i].recov_pulse;
      end
   end

   // RAM mode with the report override hides checkstops from the core pins
   assign block_in_ram = ram_mode & xstop_report_ovride;

   always_ff @(posedge nclk)
   begin
      if (rst)
      begin
         ext_xstop_q  <= 1'b0;
         xstop_q      <= '0;
         xstop_out_q  <= '0;
         lxstop_out_q <= '0;
      end
      else
      begin
         ext_xstop_q  <= ext_checkstop;
         xstop_q      <= xstop_int;
         xstop_out_q  <= block_in_ram ? '0 : xstop_int;
         lxstop_out_q <= block_in_ram ? '0 : lxstop_int;
      end
   end

   // A FIR keeps capturing through its own checkstop, only others freeze it
   always_comb
   begin
      for (int i = 0; i < NUM_FIRS; i++)
      begin
         block[i] = ext_xstop_q | (|(xstop_q & ~(NUM_FIRS'(1) << i)));
      end
   end

   always_comb
   begin
      for (int t = 0; t < NUM_THREADS; t++)
      begin
         thread_xstop[t] = xstop_int[0] | lxstop_int[0] | xstop_int[t+1] | lxstop_int[t+1];
      end
   end

   assign checkstop         = xstop_out_q;
   assign local_checkstop   = lxstop_out_q;
   assign trace_error       = |trace_int;
   assign any_fir_xstop     = |(xstop_int | lxstop_int);
   assign ram_mode_xstop    = ram_mode & any_fir_xstop;
   assign gate_rec_err_cntr = |recov_pulse;

   a_ram_override : assert property (
      @(posedge nclk) disable iff (rst)
      block_in_ram |=> (checkstop == '0)
   );

endmodule

// ==== design/fir_pkg.sv ====
//****************************
// Shared sizes, register offsets, reset values and bus structs
// for the core FIR block. Modules take it by wildcard import.
//****************************

package fir_pkg;

   localparam int NUM_THREADS      = 2;
   localparam int NUM_FIRS         = NUM_THREADS + 1;
   localparam int CORE_FIR_WIDTH   = 28;
   localparam int THREAD_FIR_WIDTH = 15;
   localparam int REG_WORD         = 32;
   localparam int UNIT_SEL_WIDTH   = 2;
   localparam int OFFSET_WIDTH     = 4;

   // Offsets inside one FIR's register window
   localparam logic [OFFSET_WIDTH-1:0] OFS_FIR      = 4'd0;
   localparam logic [OFFSET_WIDTH-1:0] OFS_FIR_AND  = 4'd1;
   localparam logic [OFFSET_WIDTH-1:0] OFS_FIR_OR   = 4'd2;
   localparam logic [OFFSET_WIDTH-1:0] OFS_ACT0     = 4'd3;
   localparam logic [OFFSET_WIDTH-1:0] OFS_ACT1     = 4'd4;
   localparam logic [OFFSET_WIDTH-1:0] OFS_MASK     = 4'd6;
   localparam logic [OFFSET_WIDTH-1:0] OFS_MASK_AND = 4'd7;
   localparam logic [OFFSET_WIDTH-1:0] OFS_MASK_OR  = 4'd8;

   localparam logic [CORE_FIR_WIDTH-1:0]   CORE_MASK_INIT   = 28'hFFFFFFF;
   localparam logic [CORE_FIR_WIDTH-1:0]   CORE_ACT0_INIT   = 28'h0000390;
   localparam logic [CORE_FIR_WIDTH-1:0]   CORE_ACT1_INIT   = 28'hFFFFFFE;
   localparam logic [THREAD_FIR_WIDTH-1:0] THREAD_MASK_INIT = 15'h7FFF;
   localparam logic [THREAD_FIR_WIDTH-1:0] THREAD_ACT0_INIT = 15'h2AB3;
   localparam logic [THREAD_FIR_WIDTH-1:0] THREAD_ACT1_INIT = 15'h7FFF;

   // External register port
   typedef struct packed {
      logic                      wr;
      logic [UNIT_SEL_WIDTH-1:0] unit_sel;
      logic [OFFSET_WIDTH-1:0]   offset;
      logic [REG_WORD-1:0]       wdata;
   } reg_req_t;

   // Write request already qualified for a single FIR
   typedef struct packed {
      logic                    wr;
      logic [OFFSET_WIDTH-1:0] offset;
      logic [REG_WORD-1:0]     wdata;
   } fir_write_t;

   typedef struct packed {
      logic [REG_WORD-1:0] fir;
      logic [REG_WORD-1:0] mask;
      logic [REG_WORD-1:0] act0;
      logic [REG_WORD-1:0] act1;
   } fir_view_t;

   typedef struct packed {
      logic xstop;
      logic lxstop;
      logic recov;
      logic trace;
      logic recov_pulse;
   } fir_status_t;

endpackage

// ==== design/fir_reg_access.sv ====
//****************************
// Register port decode. Steers writes to the selected FIR and
// returns its register contents as combinational read data.
//****************************

`timescale 1ns/1ps

module fir_reg_access
   import fir_pkg::*;
(
   input  reg_req_t                   req,
   input  fir_view_t  [NUM_FIRS-1:0]  views,
   output fir_write_t [NUM_FIRS-1:0]  writes,
   output logic       [REG_WORD-1:0]  rdata
);

   logic [NUM_FIRS-1:0] wr_vec;
   fir_view_t           sel_view;

   always_comb
   begin
      for (int i = 0; i < NUM_FIRS; i++)
      begin
         wr_vec[i]        = req.wr && (req.unit_sel == UNIT_SEL_WIDTH'(i));
         writes[i].wr     = wr_vec[i];
         writes[i].offset = req.offset;
         writes[i].wdata  = req.wdata;
      end
   end

   // An unused unit select leaves the view at zero
   always_comb
   begin
      sel_view = '0;
      if (req.unit_sel < NUM_FIRS)
      begin
         sel_view = views[req.unit_sel];
      end
   end

   // The AND and OR aliases read back the register they modify
   always_comb
   begin
      case (req.offset)
         OFS_FIR, OFS_FIR_AND, OFS_FIR_OR:    rdata = sel_view.fir;
         OFS_ACT0:                            rdata = sel_view.act0;
         OFS_ACT1:                            rdata = sel_view.act1;
         OFS_MASK, OFS_MASK_AND, OFS_MASK_OR: rdata = sel_view.mask;
         default:                             rdata = '0;
      endcase
   end

endmodule

// ==== design/fir_unit.sv ====
//****************************
// One fault isolation register with capture, mask and action
// registers. Instantiated once per FIR with its own width and resets.
//****************************

`timescale 1ns/1ps

module fir_unit
   import fir_pkg::*;
#(
   parameter int               WIDTH     = 8,
   parameter logic [WIDTH-1:0] MASK_INIT = '1,
   parameter logic [WIDTH-1:0] ACT0_INIT = '0,
   parameter logic [WIDTH-1:0] ACT1_INIT = '1
)
(
   input  logic             nclk,
   input  logic             rst,
   input  logic [WIDTH-1:0] err_in,
   input  logic             block,
   input  fir_write_t       wr,
   output fir_view_t        view,
   output fir_status_t      status
);

   logic [WIDTH-1:0] err_q;
   logic [WIDTH-1:0] fir_q;
   logic [WIDTH-1:0] mask_q;
   logic [WIDTH-1:0] act0_q;
   logic [WIDTH-1:0] act1_q;
   logic [WIDTH-1:0] wdata_w;
   logic [WIDTH-1:0] fir_wr;
   logic [WIDTH-1:0] active;
   logic [WIDTH-1:0] recov_capture;
   logic [1:0]       recov_hist_q;
   logic             recov_pulse_q;

   assign wdata_w = wr.wdata[WIDTH-1:0];

   // Software update of the FIR, before new errors are merged in
   always_comb
   begin
      fir_wr = fir_q;
      if (wr.wr)
      begin
         case (wr.offset)
            OFS_FIR:     fir_wr = wdata_w;
            OFS_FIR_AND: fir_wr = fir_q & wdata_w;
            OFS_FIR_OR:  fir_wr = fir_q | wdata_w;
            default:     fir_wr = fir_q;
         endcase
      end
   end

   always_ff @(posedge nclk)
   begin
      if (rst)
      begin
         err_q  <= '0;
         fir_q  <= '0;
         mask_q <= MASK_INIT;
         act0_q <= ACT0_INIT;
         act1_q <= ACT1_INIT;
      end
      else
      begin
         err_q <= err_in;
         fir_q <= block ? fir_wr : (fir_wr | err_q);
         if (wr.wr)
         begin
            case (wr.offset)
               OFS_ACT0:     act0_q <= wdata_w;
               OFS_ACT1:     act1_q <= wdata_w;
               OFS_MASK:     mask_q <= wdata_w;
               OFS_MASK_AND: mask_q <= mask_q & wdata_w;
               OFS_MASK_OR:  mask_q <= mask_q | wdata_w;
               default:      mask_q <= mask_q;
            endcase
         end
      end
   end

   // Recoverable errors are seen in the capture register, a cycle
   // ahead of the FIR, so the counter gate is not held by a sticky bit
   assign recov_capture = err_q & ~act0_q & act1_q & ~mask_q;

   always_ff @(posedge nclk)
   begin
      if (rst)
      begin
         recov_hist_q  <= '0;
         recov_pulse_q <= 1'b0;
      end
      else
      begin
         recov_hist_q  <= {recov_hist_q[0], |recov_capture};
         recov_pulse_q <= recov_hist_q[0] & ~recov_hist_q[1];
      end
   end

   assign active = fir_q & ~mask_q;

   always_comb
   begin
      status.xstop       = |(active & act0_q & ~act1_q);
      status.lxstop      = |(active & act0_q & act1_q);
      status.recov       = |(active & ~act0_q & act1_q);
      status.trace       = |(active & ~act0_q & ~act1_q);
      status.recov_pulse = recov_pulse_q;
   end

   always_comb
   begin
      view.fir  = {{(REG_WORD-WIDTH){1'b0}}, fir_q};
      view.mask = {{(REG_WORD-WIDTH){1'b0}}, mask_q};
      view.act0 = {{(REG_WORD-WIDTH){1'b0}}, act0_q};
      view.act1 = {{(REG_WORD-WIDTH){1'b0}}, act1_q};
   end

   // Only a direct or AND write may clear a bit that was already set
   a_fir_sticky : assert property (
      @(posedge nclk) disable iff (rst)
      !(wr.wr && (wr.offset == OFS_FIR || wr.offset == OFS_FIR_AND))
         |=> ((fir_q & $past(fir_q)) == $past(fir_q))
   );

endmodule

// ==== design/pc_fir_regs.sv ====
//****************************
// FIR block top for a two-thread core: one core FIR, one FIR per
// thread, the register port decode and the checkstop control.
//****************************

`timescale 1ns/1ps

module pc_fir_regs
   import fir_pkg::*;
(
   input  logic                                          nclk,
   input  logic                                          rst,
   input  reg_req_t                                      reg_req,
   input  logic [CORE_FIR_WIDTH-1:1]                     core_err,
   input  logic [NUM_THREADS-1:0][THREAD_FIR_WIDTH-1:0]  thread_err,
   input  logic                                          ext_checkstop,
   input  logic                                          ram_mode,
   input  logic                                          xstop_report_ovride,
   input  logic                                          max_rec_err_cntr,
   output logic [REG_WORD-1:0]                           rdata,
   output logic [NUM_FIRS-1:0]                           checkstop,
   output logic [NUM_FIRS-1:0]                           local_checkstop,
   output logic [NUM_FIRS-1:0]                           recov_err,
   output logic                                          trace_error,
   output logic [NUM_THREADS-1:0]                        thread_xstop,
   output logic                                          any_fir_xstop,
   output logic                                          ram_mode_xstop,
   output logic                                          gate_rec_err_cntr
);

   fir_write_t  [NUM_FIRS-1:0] writes;
   fir_view_t   [NUM_FIRS-1:0] views;
   fir_status_t [NUM_FIRS-1:0] status;
   logic        [NUM_FIRS-1:0] block;

   // Core FIR bit 0 reports the recoverable error counter at its limit
   fir_unit #(
      .WIDTH     (CORE_FIR_WIDTH),
      .MASK_INIT (CORE_MASK_INIT),
      .ACT0_INIT (CORE_ACT0_INIT),
      .ACT1_INIT (CORE_ACT1_INIT)
   ) i_core_fir (
      .nclk   (nclk),
      .rst    (rst),
      .err_in ({core_err, max_rec_err_cntr}),
      .block  (block[0]),
      .wr     (writes[0]),
      .view   (views[0]),
      .status (status[0])
   );

   for (genvar t = 0; t < NUM_THREADS; t++)
   begin : g_thread
      fir_unit #(
         .WIDTH     (THREAD_FIR_WIDTH),
         .MASK_INIT (THREAD_MASK_INIT),
         .ACT0_INIT (THREAD_ACT0_INIT),
         .ACT1_INIT (THREAD_ACT1_INIT)
      ) i_thread_fir (
         .nclk   (nclk),
         .rst    (rst),
         .err_in (thread_err[t]),
         .block  (block[t+1]),
         .wr     (writes[t+1]),
         .view   (views[t+1]),
         .status (status[t+1])
      );
   end

   fir_reg_access i_reg_access (
      .req    (reg_req),
      .views  (views),
      .writes (writes),
      .rdata  (rdata)
   );

   fir_checkstop_ctrl i_checkstop_ctrl (
      .nclk                (nclk),
      .rst                 (rst),
      .status              (status),
      .ext_checkstop       (ext_checkstop),
      .ram_mode            (ram_mode),
      .xstop_report_ovride (xstop_report_ovride),
      .block               (block),
      .checkstop           (checkstop),
      .local_checkstop     (local_checkstop),
      .recov_err           (recov_err),
      .trace_error         (trace_error),
      .thread_xstop        (thread_xstop),
      .any_fir_xstop       (any_fir_xstop),
      .ram_mode_xstop      (ram_mode_xstop),
      .gate_rec_err_cntr   (gate_rec_err_cntr)
   );

endmodule

// ==== pc_fir.f ====
design/fir_pkg.sv
design/fir_unit.sv
design/fir_reg_access.sv
design/fir_checkstop_ctrl.sv
design/pc_fir_regs.sv
bench/pc_fir_regs_tb.sv
